// ==== hw/memPkg.sv ====
package memPkg;

    localparam int ADDR_W     = 32;
    localparam int RAM_ADDR_W = 12;
    localparam int RAM_DEPTH  = 2 ** RAM_ADDR_W;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int WORD_BYTES = DATA_W / BYTE_W;
    localparam int IDX_W      = $clog2(WORD_BYTES);

    // byte count of an access, legal values 1, 2 and 4
    localparam int LEN_W = 3;

    localparam logic [ADDR_W-1:0] PC_STEP  = 32'd4;
    localparam logic [ADDR_W-1:0] RESET_PC = 32'd0;

    // controller states
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [STATE_W-1:0] ST_LOAD  = 2'd1;
    localparam logic [STATE_W-1:0] ST_STORE = 2'd2;
    localparam logic [STATE_W-1:0] ST_FETCH = 2'd3;

    // one word, seen whole or byte by byte (byte 0 at the lowest address)
    typedef union packed {
        logic [DATA_W-1:0]                 word;
        logic [WORD_BYTES-1:0][BYTE_W-1:0] bytes;
    } memWord_t;

endpackage

// ==== hw/ramBusIf.sv ====
`timescale 1ns/100ps

interface ramBusIf ();
    import memPkg::*;

    logic [RAM_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]     wdata;
    logic [BYTE_W-1:0]     rdata;
    logic                  write;

    modport ctrl (
        output addr,
        output wdata,
        output write,
        input  rdata
    );

    modport ram (
        input  addr,
        input  wdata,
        input  write,
        output rdata
    );

endinterface

// ==== hw/fetchReqIf.sv ====
`timescale 1ns/100ps

interface fetchReqIf ();
    import memPkg::*;

    // en and addr are held until done
    logic              en;
    logic [ADDR_W-1:0] addr;

    // done is a single-cycle pulse, inst valid with it
    logic              done;
    memWord_t          inst;

    modport fetcher (
        output en,
        output addr,
        input  done,
        input  inst
    );

    modport ctrl (
        input  en,
        input  addr,
        output done,
        output inst
    );

endinterface

// ==== hw/instFetcher.sv ====
`timescale 1ns/100ps

module instFetcher (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetchEn,
    input  logic                      redirect,
    input  logic [memPkg::ADDR_W-1:0] redirectPc,
    output logic                      instValid,
    output logic [memPkg::ADDR_W-1:0] instPc,
    output memPkg::memWord_t          inst,
    fetchReqIf.fetcher                req
);
    import memPkg::*;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pendPc;
    logic              inFlight;
    logic              stale;

    assign req.en   = inFlight;
    assign req.addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            inFlight  <= 1'b0;
            stale     <= 1'b0;
            instValid <= 1'b0;
        end else begin
            instValid <= 1'b0;
            if (req.done) begin
                inFlight <= fetchEn;
                stale    <= 1'b0;
                // a redirect in the done cycle also drops this instruction
                if (redirect) begin
                    pc <= redirectPc;
                end else if (stale) begin
                    pc <= pendPc;
                end else begin
                    pc        <= pc + PC_STEP;
                    instValid <= 1'b1;
                end
            end else if (redirect) begin
                if (inFlight) begin
                    // old request stays on the bus until its done
                    stale <= 1'b1;
                end else begin
                    pc       <= redirectPc;
                    inFlight <= fetchEn;
                end
            end else if (!inFlight) begin
                inFlight <= fetchEn;
            end
        end
    end

    // redirect target kept while the stale fetch drains
    always_ff @(posedge clk) begin
        if (redirect && inFlight && !req.done)
            pendPc <= redirectPc;
    end

    always_ff @(posedge clk) begin
        if (req.done && !stale && !redirect) begin
            instPc <= pc;
            inst   <= req.inst;
        end
    end

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/100ps

module memCtrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,
    input  logic                      ioBufferFull,
    input  logic                      dataEn,
    input  logic                      dataStore,
    input  logic                      dataUnsigned,
    input  logic [memPkg::LEN_W-1:0]  dataLen,
    input  logic [memPkg::ADDR_W-1:0] dataAddr,
    input  logic [memPkg::DATA_W-1:0] dataWdata,
    output logic                      dataDone,
    output memPkg::memWord_t          dataRdata,
    fetchReqIf.ctrl                   fetch,
    ramBusIf.ctrl                     ram
);
    import memPkg::*;

    logic [STATE_W-1:0]    state;
    logic [LEN_W-1:0]      stage;
    logic [LEN_W-1:0]      len;
    logic [RAM_ADDR_W-1:0] baseAddr;
    logic                  isUnsigned;
    memWord_t              storeWord;
    memWord_t              asmWord;
    memWord_t              mergedWord;
    memWord_t              extWord;
    logic [LEN_W-1:0]      addrOffset;
    logic [IDX_W-1:0]      inIdx;
    logic                  active;
    logic                  accept;
    logic                  lastStep;
    logic                  signBit;

    // a store also waits on the output buffer
    assign active = rdy && !(state == ST_STORE && ioBufferFull);

    // no accept while a done pulse is out, the client still shows its old request
    assign accept = (state == ST_IDLE) && rdy && !dataDone && !fetch.done
                    && (dataEn || fetch.en);

    // loads and fetches need one more step for the last byte to come back
    assign lastStep = (state == ST_STORE) ? (stage == len - 1'b1) : (stage == len);

    always_comb begin
        addrOffset = stage;
        // stalled: re-read the byte in flight so rdata keeps it
        if (!rdy && stage != '0)
            addrOffset = stage - 1'b1;
    end

    assign ram.addr  = baseAddr + RAM_ADDR_W'(addrOffset);
    assign ram.wdata = storeWord.bytes[stage[IDX_W-1:0]];
    assign ram.write = (state == ST_STORE) && active;

    // byte arriving now belongs to the previous stage
    assign inIdx = IDX_W'(stage - 1'b1);

    always_comb begin
        mergedWord = asmWord;
        mergedWord.bytes[inIdx] = ram.rdata;
    end

    always_comb begin
        signBit = 1'b0;
        extWord = mergedWord;
        if (len == LEN_W'(1)) begin
            signBit = !isUnsigned && mergedWord.bytes[0][BYTE_W-1];
            extWord.word = {{(DATA_W - BYTE_W){signBit}}, mergedWord.bytes[0]};
        end else if (len == LEN_W'(2)) begin
            signBit = !isUnsigned && mergedWord.bytes[1][BYTE_W-1];
            extWord.word = {{(DATA_W - 2 * BYTE_W){signBit}},
                            mergedWord.bytes[1], mergedWord.bytes[0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            stage      <= '0;
            dataDone   <= 1'b0;
            fetch.done <= 1'b0;
        end else begin
            dataDone   <= 1'b0;
            fetch.done <= 1'b0;
            if (accept) begin
                stage <= '0;
                // data wins over fetch
                if (dataEn)
                    state <= dataStore ? ST_STORE : ST_LOAD;
                else
                    state <= ST_FETCH;
            end else if (state != ST_IDLE && active) begin
                if (lastStep) begin
                    state <= ST_IDLE;
                    stage <= '0;
                    if (state == ST_FETCH)
                        fetch.done <= 1'b1;
                    else
                        dataDone <= 1'b1;
                end else begin
                    stage <= stage + 1'b1;
                end
            end
        end
    end

    // request fields latched at accept
    always_ff @(posedge clk) begin
        if (accept) begin
            if (dataEn) begin
                baseAddr       <= dataAddr[RAM_ADDR_W-1:0];
                len            <= dataLen;
                isUnsigned     <= dataUnsigned;
                storeWord.word <= dataWdata;
            end else begin
                baseAddr <= fetch.addr[RAM_ADDR_W-1:0];
                len      <= LEN_W'(WORD_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_LOAD || state == ST_FETCH) && active && stage != '0)
            asmWord <= mergedWord;
        if (active && lastStep && state == ST_LOAD)
            dataRdata <= extWord;
        if (active && lastStep && state == ST_FETCH)
            fetch.inst <= mergedWord;
    end

endmodule

// ==== hw/byteRam.sv ====
`timescale 1ns/100ps

module byteRam (
    input logic  clk,
    ramBusIf.ram bus
);
    import memPkg::*;

    logic [BYTE_W-1:0] mem [RAM_DEPTH];

    // write edge leaves rdata unchanged
    always_ff @(posedge clk) begin
        if (bus.write)
            mem[bus.addr] <= bus.wdata;
        else
            bus.rdata <= mem[bus.addr];
    end

endmodule

// ==== hw/memSubsystem.sv ====
`timescale 1ns/100ps

module memSubsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,
    input  logic                      ioBufferFull,
    input  logic                      dataEn,
    input  logic                      dataStore,
    input  logic                      dataUnsigned,
    input  logic [memPkg::LEN_W-1:0]  dataLen,
    input  logic [memPkg::ADDR_W-1:0] dataAddr,
    input  logic [memPkg::DATA_W-1:0] dataWdata,
    output logic                      dataDone,
    output memPkg::memWord_t          dataRdata,
    input  logic                      fetchEn,
    input  logic                      redirect,
    input  logic [memPkg::ADDR_W-1:0] redirectPc,
    output logic                      instValid,
    output logic [memPkg::ADDR_W-1:0] instPc,
    output memPkg::memWord_t          inst
);

    ramBusIf   ramBus ();
    fetchReqIf fetchReq ();

    instFetcher fetcher (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instValid  (instValid),
        .instPc     (instPc),
        .inst       (inst),
        .req        (fetchReq)
    );

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataUnsigned (dataUnsigned),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .fetch        (fetchReq),
        .ram          (ramBus)
    );

    byteRam ram (
        .clk (clk),
        .bus (ramBus)
    );

endmodule

// ==== verification/memCtrl_checker.sv ====
`timescale 1ns/100ps

module memCtrlChecker (
    input logic                       clk,
    input logic                       rst,
    input logic                       rdy,
    input logic                       ioBufferFull,
    input logic [memPkg::STATE_W-1:0] state,
    input logic                       write,
    input logic                       dataDone,
    input logic                       fetchDone
);
    import memPkg::*;

    // done pulses never stretch
    dataDonePulse: assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else $error("dataDone held longer than one cycle");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else $error("fetch done held longer than one cycle");

    writeInStore: assert property (@(posedge clk)
        write |-> (state == ST_STORE && !ioBufferFull && !rst))
        else $error("RAM write outside an unblocked store");

    writeNeedsRdy: assert property (@(posedge clk) write |-> rdy)
        else $error("RAM write while rdy is low");

endmodule

bind memCtrl memCtrlChecker ctrlChk (
    .clk          (clk),
    .rst          (rst),
    .rdy          (rdy),
    .ioBufferFull (ioBufferFull),
    .state        (state),
    .write        (ram.write),
    .dataDone     (dataDone),
    .fetchDone    (fetch.done)
);

// ==== verification/memSubsystemTb.sv ====
`timescale 1ns/100ps

module memSubsystemTb;
    import memPkg::*;

    localparam int N_RAND    = 40;
    localparam int N_LAT     = 6;
    localparam int N_FETCH   = 16;
    localparam int N_MIXED   = 40;
    localparam int MAX_STALL = 10;
    // fill stores, random pairs, latency probes, fetches, mixed pairs
    localparam int N_OPS = RAM_DEPTH / WORD_BYTES + 2 * N_RAND + N_LAT + 2 * N_FETCH
                           + 4 * N_MIXED;
    localparam int CYCLE_LIMIT = N_OPS * (5 + MAX_STALL) * 2;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              ioBufferFull;
    logic              dataEn;
    logic              dataStore;
    logic              dataUnsigned;
    logic [LEN_W-1:0]  dataLen;
    logic [ADDR_W-1:0] dataAddr;
    logic [DATA_W-1:0] dataWdata;
    logic              dataDone;
    memWord_t          dataRdata;
    logic              fetchEn;
    logic              redirect;
    logic [ADDR_W-1:0] redirectPc;
    logic              instValid;
    logic [ADDR_W-1:0] instPc;
    memWord_t          inst;

    logic [BYTE_W-1:0] mirror [RAM_DEPTH];
    logic [15:0]       lfsr;
    logic              expIsLoad [$];
    memWord_t          expWord [$];
    logic [ADDR_W-1:0] expPc;
    int                instCount;
    int                cycles = 0;
    logic              rdyEdge1;
    logic              rdyEdge2;
    logic              stallMode;

    memSubsystem uut (.*);

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [LEN_W-1:0] randLen();
        logic [31:0] sel;
        sel = randBits(2);
        return (sel == 0) ? LEN_W'(1) : (sel == 1) ? LEN_W'(2) : LEN_W'(4);
    endfunction

    // expected word of a load of len bytes after sign or zero extension
    function automatic memWord_t expectedLoad(input logic [BYTE_W-1:0] m [RAM_DEPTH],
                                              input logic [ADDR_W-1:0] addr,
                                              input logic [LEN_W-1:0] len, input logic uns);
        memWord_t w;
        logic     fill;
        w.word = '0;
        for (int k = 0; k < int'(len); k++)
            w.bytes[k] = m[RAM_ADDR_W'(addr + ADDR_W'(k))];
        fill = !uns && w.bytes[len - 1'b1][BYTE_W-1];
        for (int k = int'(len); k < WORD_BYTES; k++)
            w.bytes[k] = {BYTE_W{fill}};
        return w;
    endfunction

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkData(input memWord_t got, input memWord_t want);
        if (got !== want)
            abortRun($sformatf("ERR %0t: load returned %h, expected %h",
                               $time, got.word, want.word));
    endtask

    task automatic checkInst(input logic [ADDR_W-1:0] gotPc, input memWord_t gotInst,
                             input logic [ADDR_W-1:0] wantPc, input memWord_t wantInst);
        if (gotPc !== wantPc || gotInst !== wantInst)
            abortRun($sformatf("ERR %0t: fetched pc %h inst %h, expected pc %h inst %h",
                               $time, gotPc, gotInst.word, wantPc, wantInst.word));
    endtask

    task automatic driveStalls();
        rdy          = randBits(2) != 0;
        ioBufferFull = randBits(2) == 0;
    endtask

    // one data request held until dataDone
    // waited counts the falling edges
    task automatic dataAccess(input logic store, input logic uns, input logic [LEN_W-1:0] len,
                              input logic [ADDR_W-1:0] addr, output int waited);
        logic [DATA_W-1:0] wd;
        memWord_t          want;
        wd           = randBits(32);
        dataStore    = store;
        dataUnsigned = uns;
        dataLen      = len;
        dataAddr     = addr;
        dataWdata    = wd;
        dataEn       = 1'b1;
        want.word    = '0;
        if (store) begin
            for (int k = 0; k < int'(len); k++)
                mirror[RAM_ADDR_W'(addr + ADDR_W'(k))] = wd[BYTE_W*k +: BYTE_W];
        end else begin
            want = expectedLoad(mirror, addr, len, uns);
        end
        expIsLoad.push_back(!store);
        expWord.push_back(want);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (stallMode)
                driveStalls();
        end while (!dataDone);
        dataEn = 1'b0;
    endtask

    task automatic storeLoadPair(input int addrBits);
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  stLen;
        logic [LEN_W-1:0]  ldLen;
        logic              uns;
        int                waited;
        addr  = randBits(addrBits);
        stLen = randLen();
        ldLen = randLen();
        uns   = randBits(1) != 0;
        dataAccess(1'b1, 1'b0, stLen, addr, waited);
        dataAccess(1'b0, uns, ldLen, addr, waited);
    endtask

    // no data request, so the fetcher can take the port
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (stallMode)
                driveStalls();
        end
    endtask

    // expPc moves to the target only once no old instruction can show up
    task automatic redirectTo(input logic [ADDR_W-1:0] target);
        redirect   = 1'b1;
        redirectPc = target;
        @(negedge clk);
        redirect = 1'b0;
        expPc    = target;
    endtask

    task automatic waitInsts(input int n);
        int target;
        target = instCount + n;
        while (instCount < target)
            @(negedge clk);
    endtask

    always @(posedge clk) begin
        rdyEdge2 = rdyEdge1;
        rdyEdge1 = rdy;
        cycles++;
        if (cycles > CYCLE_LIMIT)
            abortRun($sformatf("timeout: a completion did not arrive within %0d cycles",
                               CYCLE_LIMIT));
    end

    always @(negedge clk) begin
        logic     isLoad;
        memWord_t want;
        if (dataDone) begin
            if (expIsLoad.size() == 0)
                abortRun("dataDone pulsed with no data request outstanding");
            isLoad = expIsLoad.pop_front();
            want   = expWord.pop_front();
            if (isLoad)
                checkData(dataRdata, want);
            if (!rdyEdge1)
                abortRun("dataDone pulsed after an edge with rdy low");
        end
        if (instValid) begin
            if (!rdyEdge2)
                abortRun("instValid followed a fetch done taken with rdy low");
            checkInst(instPc, inst, expPc, expectedLoad(mirror, expPc, LEN_W'(4), 1'b1));
            expPc = expPc + 32'd4;
            instCount++;
        end
    end

    initial begin
        logic [LEN_W-1:0] len;
        logic             store;
        int               waited;
        int               want;
        clk          = 1'b0;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataUnsigned = 1'b0;
        dataLen      = '0;
        dataAddr     = '0;
        dataWdata    = '0;
        fetchEn      = 1'b0;
        redirect     = 1'b0;
        redirectPc   = '0;
        lfsr         = 16'd26470;
        stallMode    = 1'b0;
        instCount    = 0;
        expPc        = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // whole RAM gets known contents first
        for (int a = 0; a < RAM_DEPTH; a += WORD_BYTES)
            dataAccess(1'b1, 1'b0, LEN_W'(4), ADDR_W'(a), waited);
        repeat (N_RAND) storeLoadPair(RAM_ADDR_W);

        // isolated latency with the controller idle before each request
        for (int i = 0; i < N_LAT; i++) begin
            len   = (i % 3 == 0) ? LEN_W'(1) : (i % 3 == 1) ? LEN_W'(2) : LEN_W'(4);
            store = i >= 3;
            @(negedge clk);
            dataAccess(store, i[0], len, randBits(RAM_ADDR_W), waited);
            want = store ? int'(len) : int'(len) + 1;
            if (waited - 1 != want)
                abortRun($sformatf("ERR %0t: %0d-byte access took %0d cycles, expected %0d",
                                   $time, len, waited - 1, want));
        end

        // fetch stream from the upper half while later data stays below 0x400
        fetchEn = 1'b1;
        redirectTo(32'h800);
        waitInsts(N_FETCH);

        // redirects two cycles into a running fetch
        for (int i = 0; i < 3; i++) begin
            while (!instValid)
                @(negedge clk);
            repeat (2) @(negedge clk);
            redirectTo(32'hC00 + 32'h100 * i);
            waitInsts(4);
        end

        redirectTo(32'h800);
        stallMode = 1'b1;
        // gaps between pairs let fetches run under the stalls too
        repeat (N_MIXED) begin
            storeLoadPair(10);
            idleCycles(2 + int'(randBits(3)));
        end
        stallMode    = 1'b0;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        waitInsts(4);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
hw/memPkg.sv
hw/ramBusIf.sv
hw/fetchReqIf.sv
hw/instFetcher.sv
hw/memCtrl.sv
hw/byteRam.sv
hw/memSubsystem.sv
verification/memCtrl_checker.sv
verification/memSubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert -Wno-fatal -f files.f --top-module memSubsystemTb \
    -Mdir "$BUILD_DIR" -o memSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/memSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "TEST PASSED" "$LOG"; then
    exit 0
fi
exit 1
